/* dv/pc_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pc_unit_config.svh"

module pc_unit_tb;

   localparam int XLEN        = `PC_XLEN;
   localparam int STALL_LIMIT = 4;         // cycles one instruction may take
   localparam int WATCHDOG_NS = 1_000_000;
   localparam core_types_pkg::xlen_t BOOT_ADDR = core_types_pkg::xlen_t'(`PC_BOOT_ADDR);
   localparam core_types_pkg::xlen_t STEP      = core_types_pkg::xlen_t'(`PC_STEP);
   localparam core_types_pkg::xlen_t JALR_MASK = ~core_types_pkg::xlen_t'(1);

   logic                  clk;
   logic                  rst_n;
   logic                  inst_valid, branch, jump, jalr, rs1_busy;
   logic                  ebreak, ecall, mret, mtvec_we, stall;
   pc_ctrl_pkg::br_op_e   br_op;
   core_types_pkg::imm_t  imm;
   core_types_pkg::xlen_t rs1_data, rs1_late_data, cmp_a, cmp_b, mtvec_wdata, pc;

   // reference model state
   core_types_pkg::xlen_t m_pc, m_mtvec, m_mepc, m_late_imm, exp_next;
   logic                  m_wait;
   logic                  exp_stall;
   logic [31:0]           rng_state;
   int                    errors;

   pc_unit dut_i (
      .clk (clk), .rst_n (rst_n), .inst_valid (inst_valid), .branch (branch),
      .br_op (br_op), .jump (jump), .jalr (jalr), .imm (imm), .rs1_data (rs1_data),
      .rs1_busy (rs1_busy), .rs1_late_data (rs1_late_data), .cmp_a (cmp_a),
      .cmp_b (cmp_b), .ebreak (ebreak), .ecall (ecall), .mret (mret),
      .mtvec_we (mtvec_we), .mtvec_wdata (mtvec_wdata), .pc (pc), .stall (stall)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   initial begin
      #WATCHDOG_NS;
      $display("ERROR: simulation ran past its time limit");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] rand32();
      logic [31:0] s;
      s = rng_state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      rng_state = s;
      return s;
   endfunction

   function automatic core_types_pkg::xlen_t rand64();
      return {rand32(), rand32()};
   endfunction

   // even immediate, sign-extended from 21 bits like a jal offset
   function automatic core_types_pkg::imm_t rand_imm();
      logic [31:0] r;
      r = rand32();
      return {{(XLEN-21){r[20]}}, r[20:1], 1'b0};
   endfunction

   function automatic pc_ctrl_pkg::br_op_e rand_br_op();
      case (rand32() % 6)
         0:       return pc_ctrl_pkg::BR_EQ;
         1:       return pc_ctrl_pkg::BR_NE;
         2:       return pc_ctrl_pkg::BR_LT;
         3:       return pc_ctrl_pkg::BR_GE;
         4:       return pc_ctrl_pkg::BR_LTU;
         default: return pc_ctrl_pkg::BR_GEU;
      endcase
   endfunction

   task automatic pick_operands(output core_types_pkg::xlen_t a, output core_types_pkg::xlen_t b);
      logic [31:0] mode;
      mode = rand32();
      a = rand64();
      case (mode[1:0])
         2'd0:    b = a;                                   // equal pair
         2'd1:    b = rand64();
         2'd2:    b = {~a[XLEN-1], a[XLEN-2:0]};           // opposite sign
         default: b = core_types_pkg::xlen_t'($signed(mode[31:24]));
      endcase
   endtask

   function automatic logic branch_holds(input pc_ctrl_pkg::br_op_e op,
                                         input core_types_pkg::xlen_t a,
                                         input core_types_pkg::xlen_t b);
      logic below_u;
      logic below_s;
      below_u = (a < b);
      // differing signs settle a signed compare by themselves
      below_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : below_u;
      case (op)
         pc_ctrl_pkg::BR_EQ:  return a == b;
         pc_ctrl_pkg::BR_NE:  return a != b;
         pc_ctrl_pkg::BR_LT:  return below_s;
         pc_ctrl_pkg::BR_GE:  return !below_s;
         pc_ctrl_pkg::BR_LTU: return below_u;
         pc_ctrl_pkg::BR_GEU: return !below_u;
         default:             return 1'b0;
      endcase
   endfunction

   task automatic check_equal(input core_types_pkg::xlen_t actual,
                              input core_types_pkg::xlen_t expected, input string what);
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at time %0t: %s, got %h expected %h", $time, what, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic drive_idle();
      {inst_valid, branch, jump, jalr, rs1_busy} = '0;
      {ebreak, ecall, mret, mtvec_we} = '0;
      br_op = pc_ctrl_pkg::BR_EQ;
      {imm, rs1_data, rs1_late_data, cmp_a, cmp_b, mtvec_wdata} = '0;
   endtask

   task automatic drive_random();
      logic [31:0] r;
      r = rand32();
      inst_valid = (r[2:0] != 3'd0);
      branch     = (r[4:3] == 2'd0);
      jump       = (r[6:5] == 2'd0);
      jalr       = r[7];
      rs1_busy   = (r[9:8] == 2'd0);
      ebreak     = (r[12:10] == 3'd0);
      ecall      = (r[15:13] == 3'd0);
      mret       = (r[18:16] == 3'd0);
      mtvec_we   = (r[21:19] == 3'd0);
      br_op      = rand_br_op();
      pick_operands(cmp_a, cmp_b);
      imm           = rand_imm();
      rs1_data      = rand64();
      rs1_late_data = rand64();
      mtvec_wdata   = rand64();
   endtask

   // next pc and stall by the priority rules, old CSR values used for this cycle
   task automatic predict();
      exp_next  = m_pc;
      exp_stall = 1'b0;
      if (m_wait) begin
         exp_next = (rs1_late_data + m_late_imm) & JALR_MASK;
         m_wait   = 1'b0;
      end else if (inst_valid) begin
         if (branch) begin
            exp_next = branch_holds(br_op, cmp_a, cmp_b) ? m_pc + imm : m_pc + STEP;
         end else if (jump && !jalr) begin
            exp_next = m_pc + imm;
         end else if (jump && rs1_busy) begin
            exp_stall  = 1'b1;
            m_wait     = 1'b1;
            m_late_imm = imm;
         end else if (jump) begin
            exp_next = (rs1_data + imm) & JALR_MASK;
         end else if (ebreak) begin
            exp_next = BOOT_ADDR;
         end else if (ecall) begin
            exp_next = m_mtvec;
            m_mepc   = m_pc;
         end else if (mret) begin
            exp_next = m_mepc;
         end else begin
            exp_next = m_pc + STEP;
         end
      end
      if (mtvec_we) m_mtvec = {mtvec_wdata[XLEN-1:2], 2'b00};
   endtask

   // one clock: stall checked mid-cycle, pc checked just after the edge
   task automatic step(output logic stall_seen);
      #10;
      predict();
      check_equal(core_types_pkg::xlen_t'(stall), core_types_pkg::xlen_t'(exp_stall), "stall");
      stall_seen = stall;
      @(posedge clk);
      #2;
      m_pc = exp_next;
      check_equal(pc, m_pc, "pc");
   endtask

   // inputs stay steady until the instruction leaves the stall
   task automatic issue(output int stall_cycles);
      logic st;
      int   cycles;
      cycles       = 0;
      stall_cycles = 0;
      st           = 1'b1;
      while (st) begin
         if (cycles >= STALL_LIMIT) begin
            $display("ERROR: instruction still stalled after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $fatal(1, "stall timeout");
         end else begin
            step(st);
            cycles++;
            if (st) stall_cycles++;
         end
      end
   endtask

   initial begin
      int                    n;
      core_types_pkg::xlen_t trap_pc;
      core_types_pkg::xlen_t vec;
      rng_state = 32'h7859d418;
      errors    = 0;
      drive_idle();
      rst_n = 1'b0;
      {m_pc, m_mtvec, m_mepc, m_late_imm} = {BOOT_ADDR, {3 * XLEN{1'b0}}};
      m_wait = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_equal(pc, BOOT_ADDR, "pc after reset");
      check_equal(core_types_pkg::xlen_t'(stall), '0, "stall after reset");

      // strobes without inst_valid leave the pc alone
      for (int i = 0; i < 5; i++) begin
         drive_random();
         inst_valid = 1'b0;
         mtvec_we   = 1'b0;
         issue(n);
      end

      for (int i = 0; i < 300; i++) begin
         drive_idle();
         {inst_valid, branch} = 2'b11;
         br_op = rand_br_op();
         pick_operands(cmp_a, cmp_b);
         imm = rand_imm();
         issue(n);
      end

      for (int i = 0; i < 100; i++) begin
         drive_idle();
         {inst_valid, jump} = 2'b11;
         jalr     = rand32() % 2 == 0;
         imm      = rand_imm();
         rs1_data = rand64();
         issue(n);
      end

      for (int i = 0; i < 40; i++) begin
         drive_idle();
         {inst_valid, jump, jalr, rs1_busy} = 4'hf;
         imm           = rand_imm();
         rs1_data      = rand64();   // stale value, must not be used
         rs1_late_data = rand64();
         issue(n);
         check_equal(core_types_pkg::xlen_t'(n), 1, "stall cycles of a busy jalr");
      end

      for (int i = 0; i < 20; i++) begin
         drive_idle();
         mtvec_we    = 1'b1;
         mtvec_wdata = rand64();
         vec         = {mtvec_wdata[XLEN-1:2], 2'b00};
         issue(n);
         drive_idle();
         {inst_valid, ecall} = 2'b11;
         trap_pc = m_pc;
         issue(n);
         check_equal(pc, vec, "ecall target");
         drive_idle();
         inst_valid = 1'b1;
         repeat (3) issue(n);
         mret = 1'b1;
         issue(n);
         check_equal(pc, trap_pc, "mret target");
         drive_idle();
         {inst_valid, ebreak} = 2'b11;
         issue(n);
         check_equal(pc, BOOT_ADDR, "ebreak target");
      end

      // long mix, overlapping strobes sort out by priority
      for (int i = 0; i < 2000; i++) begin
         drive_random();
         issue(n);
      end

      drive_idle();
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* include/pc_unit_config.svh */
`ifndef PC_UNIT_CONFIG_SVH
`define PC_UNIT_CONFIG_SVH

// register data and address width
`define PC_XLEN 64

// reset target, also where ebreak returns to
`define PC_BOOT_ADDR 64'h8000_0000

// one 32-bit instruction per fetch
`define PC_STEP 4

`endif

/* pc_unit.f */
+incdir+include
src/core_types_pkg.sv
src/pc_ctrl_pkg.sv
src/branch_cmp.sv
src/target_gen.sv
src/trap_csr.sv
src/pc_ctrl.sv
src/pc_unit.sv
dv/pc_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pc_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module pc_unit_tb \
   --Mdir obj_dir \
   -f pc_unit.f

# the pipeline keeps going on a fatal stop so the log decides the result
./obj_dir/Vpc_unit_tb 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

/* src/branch_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
   input  pc_ctrl_pkg::br_op_e   br_op,
   input  core_types_pkg::xlen_t cmp_a,
   input  core_types_pkg::xlen_t cmp_b,
   output logic                  taken
);

   logic eq;
   logic lt_s;
   logic lt_u;

   assign eq   = (cmp_a == cmp_b);
   assign lt_s = ($signed(cmp_a) < $signed(cmp_b));
   assign lt_u = (cmp_a < cmp_b);

   always_comb begin
      case (br_op)
         pc_ctrl_pkg::BR_EQ:  taken = eq;
         pc_ctrl_pkg::BR_NE:  taken = !eq;
         pc_ctrl_pkg::BR_LT:  taken = lt_s;
         pc_ctrl_pkg::BR_GE:  taken = !lt_s;
         pc_ctrl_pkg::BR_LTU: taken = lt_u;
         pc_ctrl_pkg::BR_GEU: taken = !lt_u;
         default:             taken = 1'b0; // funct3 2 and 3 are not branches
      endcase
   end

   // decode must never hand over the two unused funct3 codes
   always_comb begin
      if (!$isunknown(br_op)) begin
         assert (br_op inside {pc_ctrl_pkg::BR_EQ, pc_ctrl_pkg::BR_NE,
                               pc_ctrl_pkg::BR_LT, pc_ctrl_pkg::BR_GE,
                               pc_ctrl_pkg::BR_LTU, pc_ctrl_pkg::BR_GEU})
         else $error("branch_cmp: illegal br_op %0d", br_op);
      end
   end

endmodule

`default_nettype wire

/* src/core_types_pkg.sv */
`default_nettype none

`include "pc_unit_config.svh"

package core_types_pkg;

   // register data and fetch addresses share one width
   typedef logic [`PC_XLEN-1:0] xlen_t;

   // immediates come in already sign-extended by decode
   typedef logic [`PC_XLEN-1:0] imm_t;

endpackage

`default_nettype wire

/* src/pc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pc_unit_config.svh"

module pc_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  inst_valid,
   input  logic                  branch,
   input  logic                  jump,
   input  logic                  jalr,
   input  logic                  rs1_busy,
   input  logic                  ebreak,
   input  logic                  ecall,
   input  logic                  mret,
   input  logic                  taken,
   input  core_types_pkg::imm_t  imm,
   input  core_types_pkg::xlen_t next_pc,
   output core_types_pkg::xlen_t pc,
   output pc_ctrl_pkg::pc_src_e  pc_src,
   output core_types_pkg::imm_t  late_imm,
   output logic                  stall,
   output logic                  mepc_capture
);

   pc_ctrl_pkg::ctrl_state_e state;
   pc_ctrl_pkg::ctrl_state_e state_nxt;

   // source select, priority branch > jump > ebreak > ecall > mret > seq
   always_comb begin
      pc_src       = pc_ctrl_pkg::SRC_HOLD;
      stall        = 1'b0;
      mepc_capture = 1'b0;
      state_nxt    = state;
      case (state)
         pc_ctrl_pkg::ST_RUN: begin
            if (inst_valid) begin
               if (branch) begin
                  pc_src = taken ? pc_ctrl_pkg::SRC_REL : pc_ctrl_pkg::SRC_SEQ;
               end else if (jump) begin
                  if (!jalr) begin
                     pc_src = pc_ctrl_pkg::SRC_REL; // jal
                  end else if (rs1_busy) begin
                     stall     = 1'b1;              // rs1 still in flight, pc holds
                     state_nxt = pc_ctrl_pkg::ST_WAIT_RS1;
                  end else begin
                     pc_src = pc_ctrl_pkg::SRC_JALR;
                  end
               end else if (ebreak) begin
                  pc_src = pc_ctrl_pkg::SRC_BOOT;
               end else if (ecall) begin
                  pc_src       = pc_ctrl_pkg::SRC_MTVEC;
                  mepc_capture = 1'b1;
               end else if (mret) begin
                  pc_src = pc_ctrl_pkg::SRC_MEPC;
               end else begin
                  pc_src = pc_ctrl_pkg::SRC_SEQ;
               end
            end
         end
         pc_ctrl_pkg::ST_WAIT_RS1: begin
            // inst_valid ignored here, the late operand finishes the jalr
            pc_src    = pc_ctrl_pkg::SRC_LATE;
            state_nxt = pc_ctrl_pkg::ST_RUN;
         end
         default: state_nxt = pc_ctrl_pkg::ST_RUN;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= pc_ctrl_pkg::ST_RUN;
         pc    <= core_types_pkg::xlen_t'(`PC_BOOT_ADDR);
      end else begin
         state <= state_nxt;
         pc    <= next_pc; // hold is just pc fed back through target_gen
      end
   end

   // immediate of the stalled jalr, used one cycle later
   always_ff @(posedge clk) begin
      if (stall) begin
         late_imm <= imm;
      end
   end

   a_stall_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      stall |=> !stall
   ) else $error("pc_ctrl: stall held for two cycles");

   // every target the datapath produces must keep the pc half-word aligned
   a_pc_aligned: assert property (
      @(posedge clk) disable iff (!rst_n)
      pc[0] == 1'b0
   ) else $error("pc_ctrl: pc bit 0 set");

endmodule

`default_nettype wire

/* src/pc_ctrl_pkg.sv */
`default_nettype none

package pc_ctrl_pkg;

   // funct3 of the B-type group
   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } br_op_e;

   // next pc candidates
   typedef enum logic [2:0] {
      SRC_SEQ   = 3'd0, // pc + step
      SRC_REL   = 3'd1, // pc + imm, taken branch or jal
      SRC_JALR  = 3'd2, // rs1 + imm
      SRC_LATE  = 3'd3, // late rs1 + latched imm
      SRC_BOOT  = 3'd4,
      SRC_MTVEC = 3'd5,
      SRC_MEPC  = 3'd6,
      SRC_HOLD  = 3'd7
   } pc_src_e;

   typedef enum logic {
      ST_RUN      = 1'b0,
      ST_WAIT_RS1 = 1'b1
   } ctrl_state_e;

endpackage

`default_nettype wire

/* src/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  inst_valid,
   input  logic                  branch,
   input  pc_ctrl_pkg::br_op_e   br_op,
   input  logic                  jump,
   input  logic                  jalr,
   input  core_types_pkg::imm_t  imm,
   input  core_types_pkg::xlen_t rs1_data,
   input  logic                  rs1_busy,
   input  core_types_pkg::xlen_t rs1_late_data, // rs1 as it arrives after the stall
   input  core_types_pkg::xlen_t cmp_a,
   input  core_types_pkg::xlen_t cmp_b,
   input  logic                  ebreak,
   input  logic                  ecall,
   input  logic                  mret,
   input  logic                  mtvec_we,
   input  core_types_pkg::xlen_t mtvec_wdata,
   output core_types_pkg::xlen_t pc,
   output logic                  stall
);

   logic                  taken;
   logic                  mepc_capture;
   pc_ctrl_pkg::pc_src_e  pc_src;
   core_types_pkg::imm_t  late_imm;
   core_types_pkg::xlen_t next_pc;
   core_types_pkg::xlen_t mtvec;
   core_types_pkg::xlen_t mepc;

   pc_ctrl pc_ctrl_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .inst_valid   (inst_valid),
      .branch       (branch),
      .jump         (jump),
      .jalr         (jalr),
      .rs1_busy     (rs1_busy),
      .ebreak       (ebreak),
      .ecall        (ecall),
      .mret         (mret),
      .taken        (taken),
      .imm          (imm),
      .next_pc      (next_pc),
      .pc           (pc),
      .pc_src       (pc_src),
      .late_imm     (late_imm),
      .stall        (stall),
      .mepc_capture (mepc_capture)
   );

   branch_cmp branch_cmp_i (
      .br_op (br_op),
      .cmp_a (cmp_a),
      .cmp_b (cmp_b),
      .taken (taken)
   );

   target_gen target_gen_i (
      .pc_src        (pc_src),
      .pc            (pc),
      .imm           (imm),
      .rs1_data      (rs1_data),
      .late_imm      (late_imm),
      .rs1_late_data (rs1_late_data),
      .mtvec         (mtvec),
      .mepc          (mepc),
      .next_pc       (next_pc)
   );

   trap_csr trap_csr_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .mtvec_we     (mtvec_we),
      .mtvec_wdata  (mtvec_wdata),
      .mepc_capture (mepc_capture),
      .pc           (pc),
      .mtvec        (mtvec),
      .mepc         (mepc)
   );

endmodule

`default_nettype wire

/* src/target_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pc_unit_config.svh"

module target_gen (
   input  pc_ctrl_pkg::pc_src_e  pc_src,
   input  core_types_pkg::xlen_t pc,
   input  core_types_pkg::imm_t  imm,
   input  core_types_pkg::xlen_t rs1_data,
   input  core_types_pkg::imm_t  late_imm,
   input  core_types_pkg::xlen_t rs1_late_data,
   input  core_types_pkg::xlen_t mtvec,
   input  core_types_pkg::xlen_t mepc,
   output core_types_pkg::xlen_t next_pc
);

   // jalr targets drop bit 0
   localparam core_types_pkg::xlen_t ALIGN_MASK = ~core_types_pkg::xlen_t'(1);
   localparam core_types_pkg::xlen_t BOOT_ADDR  = core_types_pkg::xlen_t'(`PC_BOOT_ADDR);

   core_types_pkg::xlen_t seq_pc;
   core_types_pkg::xlen_t rel_pc;
   core_types_pkg::xlen_t jalr_pc;
   core_types_pkg::xlen_t late_pc;

   assign seq_pc  = pc + core_types_pkg::xlen_t'(`PC_STEP);
   assign rel_pc  = pc + imm;                               // branch and jal share this adder
   assign jalr_pc = (rs1_data + imm) & ALIGN_MASK;
   assign late_pc = (rs1_late_data + late_imm) & ALIGN_MASK; // second cycle of a stalled jalr

   always_comb begin
      case (pc_src)
         pc_ctrl_pkg::SRC_SEQ:   next_pc = seq_pc;
         pc_ctrl_pkg::SRC_REL:   next_pc = rel_pc;
         pc_ctrl_pkg::SRC_JALR:  next_pc = jalr_pc;
         pc_ctrl_pkg::SRC_LATE:  next_pc = late_pc;
         pc_ctrl_pkg::SRC_BOOT:  next_pc = BOOT_ADDR;
         pc_ctrl_pkg::SRC_MTVEC: next_pc = mtvec;
         pc_ctrl_pkg::SRC_MEPC:  next_pc = mepc;
         default:                next_pc = pc; // hold
      endcase
   end

endmodule

`default_nettype wire

/* src/trap_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_csr (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  mtvec_we,
   input  core_types_pkg::xlen_t mtvec_wdata,
   input  logic                  mepc_capture, // ecall taken this cycle
   input  core_types_pkg::xlen_t pc,
   output core_types_pkg::xlen_t mtvec,
   output core_types_pkg::xlen_t mepc
);

   // trap vector in direct mode only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtvec <= '0;
      end else if (mtvec_we) begin
         mtvec <= {mtvec_wdata[$bits(core_types_pkg::xlen_t)-1:2], 2'b00}; // mode bits tied off
      end
   end

   // mret comes back to the pc of the ecall itself
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mepc <= '0;
      end else if (mepc_capture) begin
         mepc <= pc;
      end
   end

   // a captured pc has to stay usable as a fetch target
   a_csr_aligned: assert property (
      @(posedge clk) disable iff (!rst_n)
      mepc_capture |=> (mepc[0] == 1'b0)
   ) else $error("trap_csr: misaligned mepc after capture");

endmodule

`default_nettype wire
